/* Makefile */
# Verilator flow for the CSR unit

VERILATOR ?= verilator
TB_TOP    ?= csrUnit_tb
RTL_TOP   ?= csrUnit
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* flist.f */
+incdir+hdl
hdl/csr_pkg.sv
hdl/csrDecode.sv
hdl/trapState.sv
hdl/interruptSelect.sv
hdl/perfCounters.sv
hdl/csrUnit.sv
tb/csrUnit_tb.sv

/* hdl/csrDecode.sv */
`timescale 1ns/1ns
`include "csr_cfg.svh"

module csrDecode (
    input  logic [11:0]               opAddr,
    input  csr_pkg::csrOp_e           opCode,
    input  csr_pkg::privLevel_e       priv,
    input  logic                      mstatusMie,
    input  logic                      mstatusMpie,
    input  csr_pkg::privLevel_e       mstatusMpp,
    input  logic [`CSR_XLEN-1:2]      mtvecBase,
    input  logic                      mtvecVectored,
    input  logic [`CSR_XLEN-1:0]      mepc,
    input  logic [`CSR_XLEN-1:0]      mcause,
    input  logic [`CSR_XLEN-1:0]      mtval,
    input  logic [`CSR_XLEN-1:0]      mscratch,
    input  logic [11:0]               mie,
    input  logic [11:0]               mip,
    input  logic [`CSR_CNT_W-1:0]     mcycle,
    input  logic [`CSR_CNT_W-1:0]     minstret,
    input  logic [2:0]                mcountinhibit,
    output logic [`CSR_XLEN-1:0]      rdData,
    output logic                      illegal
);
    import csr_pkg::*;

    logic unknown;
    logic writing;

    assign writing = (opCode != OP_READ) && (opCode != OP_MRET);

    always_comb begin
        rdData  = '0;
        unknown = 1'b0;
        case (opAddr)
            CSR_MSTATUS: begin
                rdData[3]     = mstatusMie;
                rdData[7]     = mstatusMpie;
                rdData[12:11] = mstatusMpp;
            end
            CSR_MISA:          rdData = `CSR_MISA_VAL;
            CSR_MIE:           rdData = {{(`CSR_XLEN-12){1'b0}}, mie};
            CSR_MIP:           rdData = {{(`CSR_XLEN-12){1'b0}}, mip};
            CSR_MTVEC:         rdData = {mtvecBase, 1'b0, mtvecVectored};
            CSR_MCOUNTINHIBIT: rdData = {{(`CSR_XLEN-3){1'b0}}, mcountinhibit};
            CSR_MSCRATCH:      rdData = mscratch;
            CSR_MEPC:          rdData = mepc;
            CSR_MCAUSE:        rdData = mcause;
            CSR_MTVAL:         rdData = mtval;
            CSR_MCYCLE, CSR_CYCLE:       rdData = mcycle[`CSR_XLEN-1:0];
            CSR_MCYCLEH, CSR_CYCLEH:     rdData = mcycle[`CSR_CNT_W-1:`CSR_XLEN];
            CSR_MINSTRET, CSR_INSTRET:   rdData = minstret[`CSR_XLEN-1:0];
            CSR_MINSTRETH, CSR_INSTRETH: rdData = minstret[`CSR_CNT_W-1:`CSR_XLEN];
            CSR_MARCHID:       rdData = `CSR_MARCHID_VAL;
            CSR_MIMPID:        rdData = `CSR_MIMPID_VAL;
            CSR_MVENDORID, CSR_MHARTID: rdData = '0; // single hart, no vendor
            default:           unknown = 1'b1;
        endcase
    end

    // bits 9:8 give the lowest level, 11:10 == 2'b11 is read-only
    assign illegal = unknown
                  || (opAddr[9:8] > priv)
                  || (writing && opAddr[11:10] == 2'b11);

endmodule

/* hdl/csrUnit.sv */
`timescale 1ns/1ns
`include "csr_cfg.svh"

module csrUnit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      opValid,
    output logic                      opReady,
    input  csr_pkg::csrOp_e           opCode,
    input  logic [11:0]               opAddr,
    input  logic [`CSR_XLEN-1:0]      opSrc,
    input  logic [4:0]                opImm,
    input  logic                      opDstNonZero,
    output logic                      resValid,
    input  logic                      resReady,
    output logic [`CSR_XLEN-1:0]      resData,
    output csr_pkg::resFlag_e         resFlags,
    input  logic                      trapValid,
    input  logic [`CSR_XLEN-1:0]      trapPc,
    input  logic [3:0]                trapCause,
    input  logic                      trapIsInterrupt,
    input  logic [`CSR_COMMIT_W-1:0]  commitCount,
    input  logic                      swIrq,
    input  logic                      timerIrq,
    input  logic                      extIrq,
    output csr_pkg::privLevel_e       priv,
    output logic [`CSR_XLEN-1:2]      mtvecBase,
    output logic                      mtvecVectored,
    output logic [`CSR_XLEN-1:0]      retVec,
    output logic                      irqPending,
    output csr_pkg::irqCause_e        irqCause
);
    import csr_pkg::*;

    logic                  accept;
    logic                  isMret;
    logic                  opIllegal;
    logic                  isWrite;
    logic                  wrEn;
    logic                  mretEn;
    logic [`CSR_XLEN-1:0]  operand;
    logic [`CSR_XLEN-1:0]  wrData;
    logic [`CSR_XLEN-1:0]  rdData;
    logic                  illegal;
    logic                  mstatusMie;
    logic                  mstatusMpie;
    privLevel_e            mstatusMpp;
    logic [`CSR_XLEN-1:0]  mepc;
    logic [`CSR_XLEN-1:0]  mcause;
    logic [`CSR_XLEN-1:0]  mtval;
    logic [`CSR_XLEN-1:0]  mscratch;
    logic [11:0]           mie;
    logic [11:0]           mip;
    logic [`CSR_CNT_W-1:0] mcycle;
    logic [`CSR_CNT_W-1:0] minstret;
    logic [2:0]            mcountinhibit;

    assign opReady = !resValid || resReady;
    assign accept  = opValid && opReady;
    assign isMret  = (opCode == OP_MRET);
    assign isWrite = !isMret && (opCode != OP_READ);

    // mret is only legal from machine mode
    assign opIllegal = isMret ? (priv != PRIV_MACHINE) : illegal;
    assign wrEn      = accept && isWrite && !illegal;
    assign mretEn    = accept && isMret && (priv == PRIV_MACHINE);

    assign operand = (opCode inside {OP_RWI, OP_RSI, OP_RCI})
                   ? {{(`CSR_XLEN-5){1'b0}}, opImm} : opSrc;

    always_comb begin
        case (opCode)
            OP_RW, OP_RWI: wrData = operand;
            OP_RS, OP_RSI: wrData = rdData | operand;
            OP_RC, OP_RCI: wrData = rdData & ~operand;
            default:       wrData = rdData;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            resValid <= 1'b0;
        else if (opReady)
            resValid <= opValid;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            if ((opCode == OP_RW || opCode == OP_RWI) && !opDstNonZero)
                resData <= '0; // no read side for x0 destinations
            else
                resData <= rdData;

            if (opIllegal)
                resFlags <= FLAG_ILLEGAL;
            else if (isMret)
                resFlags <= FLAG_XRET;
            else if (isWrite)
                resFlags <= FLAG_ORDERING;
            else
                resFlags <= FLAG_NONE;
        end
    end

    resHold: assert property (@(posedge clk) disable iff (rst)
        resValid && !resReady |=> $stable(resData) && $stable(resFlags));

    csrDecode i_decode (
        .opAddr(opAddr), .opCode(opCode), .priv(priv),
        .mstatusMie(mstatusMie), .mstatusMpie(mstatusMpie), .mstatusMpp(mstatusMpp),
        .mtvecBase(mtvecBase), .mtvecVectored(mtvecVectored),
        .mepc(mepc), .mcause(mcause), .mtval(mtval), .mscratch(mscratch),
        .mie(mie), .mip(mip),
        .mcycle(mcycle), .minstret(minstret), .mcountinhibit(mcountinhibit),
        .rdData(rdData), .illegal(illegal)
    );

    trapState i_trap (
        .clk(clk), .rst(rst),
        .wrEn(wrEn), .wrAddr(opAddr), .wrData(wrData), .mretEn(mretEn),
        .trapValid(trapValid), .trapPc(trapPc), .trapCause(trapCause),
        .trapIsInterrupt(trapIsInterrupt),
        .swIrq(swIrq), .timerIrq(timerIrq), .extIrq(extIrq),
        .priv(priv), .mstatusMie(mstatusMie), .mstatusMpie(mstatusMpie),
        .mstatusMpp(mstatusMpp), .mtvecBase(mtvecBase), .mtvecVectored(mtvecVectored),
        .mepc(mepc), .mcause(mcause), .mtval(mtval), .mscratch(mscratch),
        .mie(mie), .mip(mip), .retVec(retVec)
    );

    interruptSelect i_irq (
        .priv(priv), .mstatusMie(mstatusMie), .mie(mie), .mip(mip),
        .irqPending(irqPending), .irqCause(irqCause)
    );

    perfCounters i_perf (
        .clk(clk), .rst(rst),
        .wrEn(wrEn), .wrAddr(opAddr), .wrData(wrData), .commitCount(commitCount),
        .mcycle(mcycle), .minstret(minstret), .mcountinhibit(mcountinhibit)
    );

endmodule

/* hdl/csr_cfg.svh */
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// register and data width
`define CSR_XLEN 32

// full counter width, read as two words
`define CSR_CNT_W 64

// commits per cycle, 0 to 4
`define CSR_COMMIT_W 3

// RV32 with I, M and U
`define CSR_MISA_VAL 32'h4010_1100

`define CSR_MARCHID_VAL 32'h0000_0c52
`define CSR_MIMPID_VAL 32'h0000_0101

`endif

/* hdl/csr_pkg.sv */
package csr_pkg;

    typedef enum logic [1:0] {
        PRIV_USER    = 2'd0,
        PRIV_MACHINE = 2'd3
    } privLevel_e;

    typedef enum logic [11:0] {
        CSR_MSTATUS       = 12'h300,
        CSR_MISA          = 12'h301,
        CSR_MIE           = 12'h304,
        CSR_MTVEC         = 12'h305,
        CSR_MCOUNTINHIBIT = 12'h320,
        CSR_MSCRATCH      = 12'h340,
        CSR_MEPC          = 12'h341,
        CSR_MCAUSE        = 12'h342,
        CSR_MTVAL         = 12'h343,
        CSR_MIP           = 12'h344,
        CSR_MCYCLE        = 12'hB00,
        CSR_MINSTRET      = 12'hB02,
        CSR_MCYCLEH       = 12'hB80,
        CSR_MINSTRETH     = 12'hB82,
        CSR_CYCLE         = 12'hC00,
        CSR_INSTRET       = 12'hC02,
        CSR_CYCLEH        = 12'hC80,
        CSR_INSTRETH      = 12'hC82,
        CSR_MVENDORID     = 12'hF11,
        CSR_MARCHID       = 12'hF12,
        CSR_MIMPID        = 12'hF13,
        CSR_MHARTID       = 12'hF14
    } csrAddr_e;

    // immediate forms sit in the upper half, next to mret
    typedef enum logic [2:0] {
        OP_READ = 3'd0,
        OP_RW   = 3'd1,
        OP_RS   = 3'd2,
        OP_RC   = 3'd3,
        OP_MRET = 3'd4,
        OP_RWI  = 3'd5,
        OP_RSI  = 3'd6,
        OP_RCI  = 3'd7
    } csrOp_e;

    typedef enum logic [1:0] {
        FLAG_NONE     = 2'd0,
        FLAG_ILLEGAL  = 2'd1,
        FLAG_XRET     = 2'd2,
        FLAG_ORDERING = 2'd3
    } resFlag_e;

    typedef enum logic [3:0] {
        IRQ_SW    = 4'd3,
        IRQ_TIMER = 4'd7,
        IRQ_EXT   = 4'd11
    } irqCause_e;

endpackage

/* hdl/interruptSelect.sv */
`timescale 1ns/1ns

module interruptSelect (
    input  csr_pkg::privLevel_e priv,
    input  logic                mstatusMie,
    input  logic [11:0]         mie,
    input  logic [11:0]         mip,
    output logic                irqPending,
    output csr_pkg::irqCause_e  irqCause
);
    import csr_pkg::*;

    logic [11:0] active;
    logic        globalEn;

    assign active   = mie & mip;
    assign globalEn = (priv != PRIV_MACHINE) || mstatusMie; // lower levels always take it

    always_comb begin
        irqPending = 1'b0;
        irqCause   = IRQ_EXT;
        if (globalEn) begin
            if (active[IRQ_EXT]) begin
                irqPending = 1'b1;
                irqCause   = IRQ_EXT;
            end else if (active[IRQ_SW]) begin
                irqPending = 1'b1;
                irqCause   = IRQ_SW;
            end else if (active[IRQ_TIMER]) begin
                irqPending = 1'b1;
                irqCause   = IRQ_TIMER;
            end
        end
    end

endmodule

/* hdl/perfCounters.sv */
`timescale 1ns/1ns
`include "csr_cfg.svh"

module perfCounters (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wrEn,
    input  logic [11:0]               wrAddr,
    input  logic [`CSR_XLEN-1:0]      wrData,
    input  logic [`CSR_COMMIT_W-1:0]  commitCount,
    output logic [`CSR_CNT_W-1:0]     mcycle,
    output logic [`CSR_CNT_W-1:0]     minstret,
    output logic [2:0]                mcountinhibit
);
    import csr_pkg::*;

    logic [`CSR_CNT_W-1:0] cycleStep;
    logic [`CSR_CNT_W-1:0] instretStep;

    // a write to either half replaces the step for that cycle
    function automatic logic [`CSR_CNT_W-1:0] nextCount(
        input logic [`CSR_CNT_W-1:0] cur,
        input logic [`CSR_CNT_W-1:0] step,
        input logic                  wrLo,
        input logic                  wrHi,
        input logic [`CSR_XLEN-1:0]  data
    );
        logic [`CSR_CNT_W-1:0] next;
        next = cur + step;
        if (wrLo)
            next = {cur[`CSR_CNT_W-1:`CSR_XLEN], data};
        else if (wrHi)
            next = {data, cur[`CSR_XLEN-1:0]};
        return next;
    endfunction

    assign cycleStep   = mcountinhibit[0] ? '0 : `CSR_CNT_W'(1);
    assign instretStep = mcountinhibit[2] ? '0
                       : {{(`CSR_CNT_W-`CSR_COMMIT_W){1'b0}}, commitCount};

    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle        <= '0;
            minstret      <= '0;
            mcountinhibit <= '0;
        end else begin
            mcycle   <= nextCount(mcycle, cycleStep, wrEn && wrAddr == CSR_MCYCLE,
                                  wrEn && wrAddr == CSR_MCYCLEH, wrData);
            minstret <= nextCount(minstret, instretStep, wrEn && wrAddr == CSR_MINSTRET,
                                  wrEn && wrAddr == CSR_MINSTRETH, wrData);
            if (wrEn && wrAddr == CSR_MCOUNTINHIBIT)
                mcountinhibit <= {wrData[2], 1'b0, wrData[0]}; // cy and ir only
        end
    end

    commitRange: assert property (@(posedge clk) disable iff (rst)
        commitCount <= `CSR_COMMIT_W'(4));

endmodule

/* hdl/trapState.sv */
`timescale 1ns/1ns
`include "csr_cfg.svh"

module trapState (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wrEn,
    input  logic [11:0]               wrAddr,
    input  logic [`CSR_XLEN-1:0]      wrData,
    input  logic                      mretEn,
    input  logic                      trapValid,
    input  logic [`CSR_XLEN-1:0]      trapPc,
    input  logic [3:0]                trapCause,
    input  logic                      trapIsInterrupt,
    input  logic                      swIrq,
    input  logic                      timerIrq,
    input  logic                      extIrq,
    output csr_pkg::privLevel_e       priv,
    output logic                      mstatusMie,
    output logic                      mstatusMpie,
    output csr_pkg::privLevel_e       mstatusMpp,
    output logic [`CSR_XLEN-1:2]      mtvecBase,
    output logic                      mtvecVectored,
    output logic [`CSR_XLEN-1:0]      mepc,
    output logic [`CSR_XLEN-1:0]      mcause,
    output logic [`CSR_XLEN-1:0]      mtval,
    output logic [`CSR_XLEN-1:0]      mscratch,
    output logic [11:0]               mie,
    output logic [11:0]               mip,
    output logic [`CSR_XLEN-1:0]      retVec
);
    import csr_pkg::*;

    always_ff @(posedge clk) begin
        if (rst) begin
            priv          <= PRIV_MACHINE;
            mstatusMie    <= 1'b0;
            mstatusMpie   <= 1'b0;
            mstatusMpp    <= PRIV_USER;
            mtvecBase     <= '0;
            mtvecVectored <= 1'b0;
            mepc          <= '0;
            mcause        <= '0;
            mtval         <= '0;
            mscratch      <= '0;
            mie           <= '0;
            mip           <= '0;
            retVec        <= '0;
        end else begin
            mip[3]  <= swIrq;
            mip[7]  <= timerIrq;
            mip[11] <= extIrq;

            if (trapValid) begin // wins over a write in the same cycle
                mstatusMpie <= mstatusMie;
                mstatusMie  <= 1'b0;
                mstatusMpp  <= priv;
                mepc        <= {trapPc[`CSR_XLEN-1:1], 1'b0};
                mcause      <= {trapIsInterrupt, {(`CSR_XLEN-5){1'b0}}, trapCause};
                mtval       <= '0;
                priv        <= PRIV_MACHINE;
            end else if (mretEn) begin
                mstatusMie <= mstatusMpie;
                priv       <= mstatusMpp;
                mstatusMpp <= PRIV_USER;
                retVec     <= mepc;
            end else if (wrEn) begin
                case (wrAddr)
                    CSR_MSTATUS: begin
                        mstatusMie  <= wrData[3];
                        mstatusMpie <= wrData[7];
                        // only user and machine exist, anything else reads as user
                        mstatusMpp  <= (wrData[12:11] == 2'b11) ? PRIV_MACHINE : PRIV_USER;
                    end
                    CSR_MTVEC: begin
                        mtvecBase     <= wrData[`CSR_XLEN-1:2];
                        mtvecVectored <= wrData[0];
                    end
                    CSR_MIE: begin
                        mie[3]  <= wrData[3];
                        mie[7]  <= wrData[7];
                        mie[11] <= wrData[11];
                    end
                    CSR_MEPC:     mepc <= {wrData[`CSR_XLEN-1:1], 1'b0};
                    CSR_MCAUSE:   mcause <= {wrData[`CSR_XLEN-1], {(`CSR_XLEN-6){1'b0}},
                                             wrData[4:0]};
                    CSR_MTVAL:    mtval <= wrData;
                    CSR_MSCRATCH: mscratch <= wrData;
                    default: ; // mip follows the irq lines
                endcase
            end
        end
    end

    privLegal: assert property (@(posedge clk) disable iff (rst)
        priv inside {PRIV_USER, PRIV_MACHINE});

    // trap entry and mret never arrive in the same cycle
    noMretOnTrap: assert property (@(posedge clk) disable iff (rst)
        !(mretEn && trapValid));

endmodule

/* tb/csrUnit_tb.sv */
`timescale 1ns/1ns
`include "csr_cfg.svh"

module csrUnit_tb;
    import csr_pkg::*;

    localparam int TIMEOUT = 200;
    localparam logic [1:0] CMP_ANY   = 2'd0;
    localparam logic [1:0] CMP_EXACT = 2'd1;
    localparam logic [1:0] CMP_SAME  = 2'd2; // equal to the previous beat
    localparam logic [1:0] CMP_MORE  = 2'd3; // larger than the previous beat

    logic                     clk = 1'b0;
    logic                     rst = 1'b1;
    logic                     opValid;
    logic                     opReady;
    csrOp_e                   opCode;
    logic [11:0]              opAddr;
    logic [`CSR_XLEN-1:0]     opSrc;
    logic [4:0]               opImm;
    logic                     opDstNonZero;
    logic                     resValid;
    logic                     resReady;
    logic [`CSR_XLEN-1:0]     resData;
    resFlag_e                 resFlags;
    logic                     trapValid;
    logic [`CSR_XLEN-1:0]     trapPc;
    logic [3:0]               trapCause;
    logic                     trapIsInterrupt;
    logic [`CSR_COMMIT_W-1:0] commitCount;
    logic                     swIrq;
    logic                     timerIrq;
    logic                     extIrq;
    privLevel_e               priv;
    logic [`CSR_XLEN-1:2]     mtvecBase;
    logic                     mtvecVectored;
    logic [`CSR_XLEN-1:0]     retVec;
    logic                     irqPending;
    irqCause_e                irqCause;

    // expected beats, in acceptance order
    logic [31:0] expData [0:255];
    logic [1:0]  expFlag [0:255];
    logic [1:0]  expMode [0:255];
    logic [79:0] expName [0:255];
    int          wrPtr = 0;
    int          rdPtr = 0;
    logic [31:0] lastData = '0;
    logic [31:0] heldData;
    logic [31:0] headData;
    logic [31:0] headRef;
    logic [1:0]  headFlag;
    logic [1:0]  headMode;
    logic [79:0] headName;
    logic        beat;

    // reference model of the architectural state
    logic [79:0] testName = "reset";
    logic [31:0] lfsrState = 32'd75751;
    privLevel_e  expPriv = PRIV_MACHINE;
    logic [31:0] expRetVec = '0;
    logic [31:0] mst = '0;
    logic [31:0] mepcModel = '0;
    logic [31:0] mcauseModel = '0;
    logic [31:0] mtvecModel = '0;
    logic [31:0] scratch = '0;
    logic [11:0] mieModel = '0;
    logic        irqCheck = 1'b0;
    logic [4:0]  irqWant = '0;
    logic [4:0]  irqSeen;

    csrUnit i_dut (.*);

    always #20 clk = ~clk;

    assign beat     = resValid && resReady;
    assign headData = expData[rdPtr[7:0]];
    assign headFlag = expFlag[rdPtr[7:0]];
    assign headMode = expMode[rdPtr[7:0]];
    assign headName = expName[rdPtr[7:0]];
    assign headRef  = (headMode == CMP_EXACT) ? headData : lastData;
    assign irqSeen  = {irqPending, irqCause};

    always @(posedge clk) begin
        if (!rst && beat) begin
            rdPtr    <= rdPtr + 1;
            lastData <= resData;
        end
        heldData <= resData;
    end

    task automatic reportMismatch(input logic [79:0] name, input logic [31:0] expV,
                                  input logic [31:0] actV);
        $display("[ERROR] %0s: expected 0x%08h, actual 0x%08h", name, expV, actV);
        $display("STATUS: FAIL");
        $fatal(1, "value mismatch");
    endtask

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "run aborted");
    endtask

    beatExpected: assert property (@(posedge clk) disable iff (rst)
        beat |-> rdPtr < wrPtr)
        else abortRun("a result beat arrived with no accepted micro-op behind it");

    beatFlag: assert property (@(posedge clk) disable iff (rst)
        beat |-> resFlags == headFlag)
        else reportMismatch($sampled(headName), {30'b0, $sampled(headFlag)},
                            {30'b0, $sampled(resFlags)});

    beatData: assert property (@(posedge clk) disable iff (rst)
        beat |-> (headMode == CMP_ANY)
              || (headMode == CMP_EXACT && resData == headData)
              || (headMode == CMP_SAME && resData == lastData)
              || (headMode == CMP_MORE && resData > lastData))
        else reportMismatch($sampled(headName), $sampled(headRef), $sampled(resData));

    stallHold: assert property (@(posedge clk) disable iff (rst)
        resValid && !resReady |=> resValid && resData == heldData)
        else reportMismatch(testName, $sampled(heldData), $sampled(resData));

    privMatch: assert property (@(posedge clk) disable iff (rst)
        priv == expPriv)
        else reportMismatch(testName, {30'b0, $sampled(expPriv)}, {30'b0, $sampled(priv)});

    retVecMatch: assert property (@(posedge clk) disable iff (rst)
        retVec == expRetVec)
        else reportMismatch(testName, $sampled(expRetVec), $sampled(retVec));

    mtvecMatch: assert property (@(posedge clk) disable iff (rst)
        {mtvecBase, 1'b0, mtvecVectored} == mtvecModel)
        else reportMismatch(testName, $sampled(mtvecModel),
                            {$sampled(mtvecBase), 1'b0, $sampled(mtvecVectored)});

    irqMatch: assert property (@(posedge clk) disable iff (rst)
        irqCheck |-> irqPending == irqWant[4] && (!irqWant[4] || irqCause == irqWant[3:0]))
        else reportMismatch(testName, {27'b0, $sampled(irqWant)}, {27'b0, $sampled(irqSeen)});

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            r = {r[30:0], lfsrState[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] mstatusWord(input logic mieBit, input logic mpieBit,
                                                input logic [1:0] mpp);
        logic [31:0] w;
        w = '0;
        w[3] = mieBit;
        w[7] = mpieBit;
        w[12:11] = (mpp == 2'b11) ? 2'b11 : 2'b00; // only user and machine exist
        return w;
    endfunction

    task automatic tick();
        logic [31:0] r;
        @(negedge clk);
        r = randBits(2);
        resReady = (r[1:0] != 2'b00); // ready about 3 cycles in 4
    endtask

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic sendOp(input csrOp_e code, input logic [11:0] addr, input logic [31:0] src,
                          input logic [4:0] imm, input logic dst, input logic [1:0] mode,
                          input logic [31:0] data, input resFlag_e flag);
        int waited;
        waited = 0;
        opValid      = 1'b1;
        opCode       = code;
        opAddr       = addr;
        opSrc        = src;
        opImm        = imm;
        opDstNonZero = dst;
        while (resValid && !resReady) begin
            if (waited == TIMEOUT)
                abortRun("micro-op was never accepted");
            tick();
            waited++;
        end
        expData[wrPtr[7:0]] = data;
        expFlag[wrPtr[7:0]] = flag;
        expMode[wrPtr[7:0]] = mode;
        expName[wrPtr[7:0]] = testName;
        wrPtr++;
        tick();
        opValid = 1'b0;
    endtask

    task automatic raiseTrap();
        logic [31:0] r;
        r = randBits(32);
        trapPc = r;
        r = randBits(5);
        trapCause       = r[3:0];
        trapIsInterrupt = r[4];
        trapValid       = 1'b1;
        tick();
        trapValid   = 1'b0;
        mepcModel   = {trapPc[31:1], 1'b0};
        mcauseModel = {trapIsInterrupt, 27'b0, trapCause};
        mst         = mstatusWord(1'b0, mst[3], expPriv);
        expPriv     = PRIV_MACHINE;
    endtask

    task automatic issueMret();
        if (expPriv == PRIV_MACHINE) begin
            sendOp(OP_MRET, 12'h000, '0, '0, 1'b1, CMP_EXACT, '0, FLAG_XRET);
            expPriv   = privLevel_e'(mst[12:11]);
            expRetVec = mepcModel;
            mst       = mstatusWord(mst[7], mst[7], 2'b00);
        end else begin
            sendOp(OP_MRET, 12'h000, '0, '0, 1'b1, CMP_EXACT, '0, FLAG_ILLEGAL);
        end
    endtask

    task automatic checkIrqCase(input logic [2:0] lines);
        logic [2:0] act;
        irqCheck = 1'b0;
        swIrq    = lines[0];
        timerIrq = lines[1];
        extIrq   = lines[2];
        tick(); // mip picks the lines up on this edge
        act = lines & {mieModel[11], mieModel[7], mieModel[3]};
        if (!((expPriv != PRIV_MACHINE) || mst[3]) || act == 3'b000)
            irqWant = {1'b0, IRQ_EXT};
        else if (act[2])
            irqWant = {1'b1, IRQ_EXT};
        else if (act[0])
            irqWant = {1'b1, IRQ_SW};
        else
            irqWant = {1'b1, IRQ_TIMER};
        irqCheck = 1'b1;
        tick();
        irqCheck = 1'b0;
    endtask

    initial begin
        logic [31:0] rnd;
        logic [4:0]  imm;
        logic [31:0] sum;
        int          waited;
        opValid = 1'b0;
        opCode = OP_READ;
        opAddr = '0;
        opSrc = '0;
        opImm = '0;
        opDstNonZero = 1'b1;
        resReady = 1'b1;
        trapValid = 1'b0;
        trapPc = '0;
        trapCause = '0;
        trapIsInterrupt = 1'b0;
        commitCount = '0;
        swIrq = 1'b0;
        timerIrq = 1'b0;
        extIrq = 1'b0;
        for (int i = 0; i < 8; i++)
            @(negedge clk);
        rst = 1'b0;

        testName = "mscratch";
        for (int i = 0; i < 4; i++) begin
            rnd = randBits(32);
            sendOp(OP_RW, CSR_MSCRATCH, rnd, '0, 1'b1, CMP_EXACT, scratch, FLAG_ORDERING);
            scratch = rnd;
            rnd = randBits(32);
            sendOp(OP_RS, CSR_MSCRATCH, rnd, '0, 1'b1, CMP_EXACT, scratch, FLAG_ORDERING);
            scratch = scratch | rnd;
            rnd = randBits(32);
            sendOp(OP_RC, CSR_MSCRATCH, rnd, '0, 1'b1, CMP_EXACT, scratch, FLAG_ORDERING);
            scratch = scratch & ~rnd;
            rnd = randBits(5);
            imm = rnd[4:0];
            sendOp(OP_RSI, CSR_MSCRATCH, '0, imm, 1'b1, CMP_EXACT, scratch, FLAG_ORDERING);
            scratch = scratch | {27'b0, imm};
            rnd = randBits(5);
            imm = rnd[4:0];
            sendOp(OP_RCI, CSR_MSCRATCH, '0, imm, 1'b1, CMP_EXACT, scratch, FLAG_ORDERING);
            scratch = scratch & ~{27'b0, imm};
        end
        sendOp(OP_RWI, CSR_MSCRATCH, '0, imm, 1'b0, CMP_EXACT, '0, FLAG_ORDERING); // x0 dest
        scratch = {27'b0, imm};
        sendOp(OP_READ, CSR_MSCRATCH, '0, '0, 1'b1, CMP_EXACT, scratch, FLAG_NONE);

        testName = "trap";
        rnd = randBits(32);
        sendOp(OP_RW, CSR_MTVEC, rnd, '0, 1'b1, CMP_EXACT, mtvecModel, FLAG_ORDERING);
        mtvecModel = {rnd[31:2], 1'b0, rnd[0]}; // mode bit 1 is not kept
        sendOp(OP_READ, CSR_MTVEC, '0, '0, 1'b1, CMP_EXACT, mtvecModel, FLAG_NONE);
        sendOp(OP_RW, CSR_MSTATUS, 32'h8, '0, 1'b1, CMP_EXACT, mst, FLAG_ORDERING);
        mst = mstatusWord(1'b1, 1'b0, 2'b00);
        raiseTrap();
        sendOp(OP_READ, CSR_MEPC, '0, '0, 1'b1, CMP_EXACT, mepcModel, FLAG_NONE);
        sendOp(OP_READ, CSR_MCAUSE, '0, '0, 1'b1, CMP_EXACT, mcauseModel, FLAG_NONE);
        sendOp(OP_READ, CSR_MSTATUS, '0, '0, 1'b1, CMP_EXACT, mst, FLAG_NONE);
        issueMret();
        sendOp(OP_READ, CSR_MSTATUS, '0, '0, 1'b1, CMP_EXACT, mst, FLAG_NONE);

        testName = "privilege";
        issueMret(); // mpp is user now
        rnd = randBits(32);
        sendOp(OP_READ, CSR_MSCRATCH, '0, '0, 1'b1, CMP_EXACT, scratch, FLAG_ILLEGAL);
        sendOp(OP_RW, CSR_MIE, rnd, '0, 1'b1, CMP_EXACT, {20'b0, mieModel}, FLAG_ILLEGAL);
        sendOp(OP_READ, CSR_CYCLE, '0, '0, 1'b1, CMP_ANY, '0, FLAG_NONE);
        issueMret();
        raiseTrap();
        sendOp(OP_READ, CSR_MSTATUS, '0, '0, 1'b1, CMP_EXACT, mst, FLAG_NONE);
        sendOp(OP_READ, CSR_MEPC, '0, '0, 1'b1, CMP_EXACT, mepcModel, FLAG_NONE);
        issueMret(); // back to user
        raiseTrap();
        sendOp(OP_RW, CSR_MARCHID, rnd, '0, 1'b1, CMP_EXACT, `CSR_MARCHID_VAL, FLAG_ILLEGAL);

        testName = "interrupt";
        sendOp(OP_RW, CSR_MIE, 32'h888, '0, 1'b1, CMP_EXACT, {20'b0, mieModel}, FLAG_ORDERING);
        mieModel = 12'h888;
        sendOp(OP_RSI, CSR_MSTATUS, '0, 5'd8, 1'b1, CMP_EXACT, mst, FLAG_ORDERING);
        mst = mstatusWord(1'b1, mst[7], mst[12:11]);
        for (int i = 0; i < 10; i++) begin
            rnd = randBits(3);
            checkIrqCase(rnd[2:0]);
        end
        sendOp(OP_RCI, CSR_MSTATUS, '0, 5'd8, 1'b1, CMP_EXACT, mst, FLAG_ORDERING);
        mst = mstatusWord(1'b0, mst[7], mst[12:11]);
        checkIrqCase(3'b111); // all masked
        checkIrqCase(3'b000);

        testName = "counters";
        sendOp(OP_RW, CSR_MINSTRETH, '0, '0, 1'b1, CMP_ANY, '0, FLAG_ORDERING);
        sendOp(OP_RW, CSR_MINSTRET, '0, '0, 1'b1, CMP_ANY, '0, FLAG_ORDERING);
        sum = '0;
        for (int i = 0; i < 24; i++) begin
            rnd = randBits(3);
            commitCount = (rnd[2:0] > 3'd4) ? rnd[2:0] - 3'd4 : rnd[2:0];
            sum = sum + {29'b0, commitCount};
            tick();
        end
        commitCount = '0;
        sendOp(OP_READ, CSR_MINSTRET, '0, '0, 1'b1, CMP_EXACT, sum, FLAG_NONE);
        sendOp(OP_RWI, CSR_MCOUNTINHIBIT, '0, 5'd1, 1'b1, CMP_EXACT, '0, FLAG_ORDERING);
        sendOp(OP_READ, CSR_MCYCLE, '0, '0, 1'b1, CMP_ANY, '0, FLAG_NONE);
        sendOp(OP_READ, CSR_MCYCLE, '0, '0, 1'b1, CMP_SAME, '0, FLAG_NONE);
        sendOp(OP_RCI, CSR_MCOUNTINHIBIT, '0, 5'd1, 1'b1, CMP_EXACT, 32'd1, FLAG_ORDERING);
        sendOp(OP_READ, CSR_MCYCLE, '0, '0, 1'b1, CMP_ANY, '0, FLAG_NONE);
        sendOp(OP_READ, CSR_MCYCLE, '0, '0, 1'b1, CMP_MORE, '0, FLAG_NONE);

        testName = "drain";
        waited = 0;
        while (rdPtr != wrPtr) begin
            if (waited == TIMEOUT)
                abortRun("result beats still missing at the end of the run");
            tick();
            waited++;
        end
        for (int i = 0; i < 6; i++)
            tick(); // room for a stray extra beat
        $display("STATUS: PASS");
        $finish;
    end

endmodule
